//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int ROB_WIDTH = 4;

	typedef logic [31:0] word_t;
	typedef logic [ROB_WIDTH-1:0] tag_t;

	// one broadcast on a result bus, also an architectural read
	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t data;
	} cdb_t;

	typedef struct packed {
		logic valid;
		word_t data;
	} rob_read_t;

	// writeback request from an execution unit
	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t data;
	} wb_req_t;

endpackage

`default_nettype wire

//--- hw/cdb_pkg.sv
`default_nettype none

package cdb_pkg;
	import core_pkg::*;

	// reservation depth per bus
	localparam int GPR_SLOTS = 3;
	localparam int FPR_SLOTS = 14;

	// fixed unit latencies, grant to broadcast
	localparam int LAT_FTOI = 3;
	localparam int LAT_FDIV = 14;
	localparam int LAT_FADD = 6;
	localparam int LAT_FMUL = 4;
	localparam int LAT_ITOF = 3;

	typedef enum logic [1:0] {
		gpr_add_sub,
		gpr_next_mov,
		gpr_lw,
		gpr_ftoi
	} gpr_unit_t;

	typedef enum logic [2:0] {
		fpr_fdiv,
		fpr_fsqrt,
		fpr_fadd_fsub,
		fpr_fmul,
		fpr_itof,
		fpr_lw,
		fpr_fmov
	} fpr_unit_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		gpr_unit_t unit;
	} gpr_slot_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		fpr_unit_t unit;
	} fpr_slot_t;

endpackage

`default_nettype wire

//--- hw/gpr_cdb_sched.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_cdb_sched
	import core_pkg::*, cdb_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    flush,
	input  tag_t    gpr_issue_tag,
	input  wb_req_t req_ftoi,
	input  wb_req_t req_lw,
	input  wb_req_t req_add_sub,
	input  wb_req_t req_next,
	input  wb_req_t req_mov,
	input  wb_req_t req_in,
	output logic    gnt_ftoi,
	output logic    gnt_lw,
	output logic    gnt_add_sub,
	output logic    gnt_next,
	output logic    gnt_mov,
	output logic    gnt_in,
	output cdb_t    cdb
);

	gpr_slot_t slot [GPR_SLOTS];
	gpr_slot_t ins [GPR_SLOTS];
	word_t next_mov_q;
	logic acc_lw;
	logic acc_add_sub;
	logic acc_next;
	logic acc_mov;

	////////////////////////////////////////////////////////////
	// grants

	assign gnt_ftoi    = 1'b1;
	assign gnt_lw      = !slot[1].valid;
	assign gnt_add_sub = gnt_lw && !req_lw.valid;
	assign gnt_next    = gnt_add_sub && !req_add_sub.valid;
	assign gnt_mov     = gnt_next && !req_next.valid;
	assign gnt_in      = !slot[0].valid;

	assign acc_lw      = req_lw.valid && gnt_lw;
	assign acc_add_sub = req_add_sub.valid && gnt_add_sub;
	assign acc_next    = req_next.valid && gnt_next;
	assign acc_mov     = req_mov.valid && gnt_mov;

	////////////////////////////////////////////////////////////
	// reservation shift register

	always_comb begin
		for (int i = 0; i < GPR_SLOTS; i++) begin
			ins[i] = '0;
		end
		ins[LAT_FTOI-1].valid = req_ftoi.valid && gnt_ftoi;
		ins[LAT_FTOI-1].tag   = req_ftoi.tag;
		ins[LAT_FTOI-1].unit  = gpr_ftoi;
		// one-cycle units, grants are already exclusive
		ins[0].valid = acc_lw || acc_add_sub || acc_next || acc_mov;
		ins[0].tag   = acc_lw ? req_lw.tag :
		               acc_add_sub ? req_add_sub.tag :
		               acc_next ? req_next.tag : req_mov.tag;
		ins[0].unit  = acc_lw ? gpr_lw :
		               acc_add_sub ? gpr_add_sub : gpr_next_mov;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < GPR_SLOTS; i++) begin
				slot[i] <= '0;
			end
		end else if (flush) begin
			for (int i = 0; i < GPR_SLOTS; i++) begin
				slot[i] <= '0;
			end
		end else begin
			// older entries move down ahead of new ones
			for (int i = 0; i < GPR_SLOTS-1; i++) begin
				slot[i] <= slot[i+1].valid ? slot[i+1] : ins[i];
			end
			slot[GPR_SLOTS-1] <= ins[GPR_SLOTS-1];
		end
	end

	// next and mov results held until broadcast
	always_ff @(posedge clk) begin
		if (acc_next) begin
			next_mov_q <= req_next.data;
		end else if (acc_mov) begin
			next_mov_q <= req_mov.data;
		end
	end

	////////////////////////////////////////////////////////////
	// broadcast

	always_comb begin
		cdb.valid = slot[0].valid || (req_in.valid && gnt_in);
		cdb.tag   = slot[0].valid ? slot[0].tag : gpr_issue_tag;
		if (!slot[0].valid) begin
			cdb.data = req_in.data;
		end else begin
			case (slot[0].unit)
				gpr_ftoi:    cdb.data = req_ftoi.data;
				gpr_lw:      cdb.data = req_lw.data;
				gpr_add_sub: cdb.data = req_add_sub.data;
				default:     cdb.data = next_mov_q;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/fpr_cdb_sched.sv
`timescale 1ns/1ps
`default_nettype none

module fpr_cdb_sched
	import core_pkg::*, cdb_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    flush,
	input  tag_t    fpr_issue_tag,
	input  wb_req_t req_fdiv,
	input  wb_req_t req_fadd_fsub,
	input  wb_req_t req_fmul,
	input  wb_req_t req_itof,
	input  wb_req_t req_lw,
	input  wb_req_t req_fmov,
	input  wb_req_t req_in,
	input  word_t   fsqrt_data,
	input  logic    fdiv_is_sqrt,
	output logic    gnt_fdiv,
	output logic    gnt_fadd_fsub,
	output logic    gnt_fmul,
	output logic    gnt_itof,
	output logic    gnt_lw,
	output logic    gnt_fmov,
	output logic    gnt_in,
	output cdb_t    cdb
);

	fpr_slot_t slot [FPR_SLOTS];
	fpr_slot_t ins [FPR_SLOTS];
	logic acc_lw;
	logic acc_fmov;

	////////////////////////////////////////////////////////////
	// grants

	// a unit is refused when the slot above its entry is taken
	assign gnt_fdiv      = 1'b1;
	assign gnt_fadd_fsub = !slot[LAT_FADD].valid;
	assign gnt_fmul      = !slot[LAT_FMUL].valid;
	assign gnt_itof      = !slot[LAT_ITOF].valid;
	assign gnt_lw        = !slot[1].valid;
	assign gnt_fmov      = gnt_lw && !req_lw.valid;
	assign gnt_in        = !slot[0].valid;

	assign acc_lw   = req_lw.valid && gnt_lw;
	assign acc_fmov = req_fmov.valid && gnt_fmov;

	////////////////////////////////////////////////////////////
	// reservation shift register

	always_comb begin
		for (int i = 0; i < FPR_SLOTS; i++) begin
			ins[i] = '0;
		end
		ins[LAT_FDIV-1].valid = req_fdiv.valid && gnt_fdiv;
		ins[LAT_FDIV-1].tag   = req_fdiv.tag;
		ins[LAT_FDIV-1].unit  = fdiv_is_sqrt ? fpr_fsqrt : fpr_fdiv;
		ins[LAT_FADD-1].valid = req_fadd_fsub.valid && gnt_fadd_fsub;
		ins[LAT_FADD-1].tag   = req_fadd_fsub.tag;
		ins[LAT_FADD-1].unit  = fpr_fadd_fsub;
		ins[LAT_FMUL-1].valid = req_fmul.valid && gnt_fmul;
		ins[LAT_FMUL-1].tag   = req_fmul.tag;
		ins[LAT_FMUL-1].unit  = fpr_fmul;
		ins[LAT_ITOF-1].valid = req_itof.valid && gnt_itof;
		ins[LAT_ITOF-1].tag   = req_itof.tag;
		ins[LAT_ITOF-1].unit  = fpr_itof;
		ins[0].valid = acc_lw || acc_fmov;
		ins[0].tag   = acc_lw ? req_lw.tag : req_fmov.tag;
		ins[0].unit  = acc_lw ? fpr_lw : fpr_fmov;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < FPR_SLOTS; i++) begin
				slot[i] <= '0;
			end
		end else if (flush) begin
			for (int i = 0; i < FPR_SLOTS; i++) begin
				slot[i] <= '0;
			end
		end else begin
			// merge a new entry only where the slot above is empty
			for (int i = 0; i < FPR_SLOTS-1; i++) begin
				slot[i] <= slot[i+1].valid ? slot[i+1] : ins[i];
			end
			slot[FPR_SLOTS-1] <= ins[FPR_SLOTS-1];
		end
	end

	////////////////////////////////////////////////////////////
	// broadcast

	always_comb begin
		cdb.valid = slot[0].valid || (req_in.valid && gnt_in);
		cdb.tag   = slot[0].valid ? slot[0].tag : fpr_issue_tag;
		if (!slot[0].valid) begin
			cdb.data = req_in.data;
		end else begin
			case (slot[0].unit)
				fpr_fdiv:      cdb.data = req_fdiv.data;
				fpr_fsqrt:     cdb.data = fsqrt_data;
				fpr_fadd_fsub: cdb.data = req_fadd_fsub.data;
				fpr_fmul:      cdb.data = req_fmul.data;
				fpr_itof:      cdb.data = req_itof.data;
				fpr_lw:        cdb.data = req_lw.data;
				default:       cdb.data = req_fmov.data;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
	import core_pkg::*;
(
	input  cdb_t      arch_read [2],
	input  rob_read_t rob_read [2],
	input  cdb_t      cdb,
	output cdb_t      read [2]
);

	logic hit [2];

	for (genvar i = 0; i < 2; i++) begin : g_port
		// bus carries the value this operand waits for
		assign hit[i] = cdb.valid && (cdb.tag == arch_read[i].tag);

		always_comb begin
			read[i].valid = arch_read[i].valid || hit[i] || rob_read[i].valid;
			read[i].tag   = arch_read[i].tag;
			if (arch_read[i].valid) begin
				read[i].data = arch_read[i].data;
			end else if (hit[i]) begin
				read[i].data = cdb.data;
			end else begin
				read[i].data = rob_read[i].data;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/writeback_bus.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_bus
	import core_pkg::*, cdb_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      flush,
	input  tag_t      gpr_issue_tag,
	input  tag_t      fpr_issue_tag,
	// integer units
	input  wb_req_t   gpr_req_ftoi,
	input  wb_req_t   gpr_req_lw,
	input  wb_req_t   gpr_req_add_sub,
	input  wb_req_t   gpr_req_next,
	input  wb_req_t   gpr_req_mov,
	input  wb_req_t   gpr_req_in,
	output logic      gpr_gnt_ftoi,
	output logic      gpr_gnt_lw,
	output logic      gpr_gnt_add_sub,
	output logic      gpr_gnt_next,
	output logic      gpr_gnt_mov,
	output logic      gpr_gnt_in,
	// float units
	input  wb_req_t   fpr_req_fdiv,
	input  wb_req_t   fpr_req_fadd_fsub,
	input  wb_req_t   fpr_req_fmul,
	input  wb_req_t   fpr_req_itof,
	input  wb_req_t   fpr_req_lw,
	input  wb_req_t   fpr_req_fmov,
	input  wb_req_t   fpr_req_in,
	input  word_t     fsqrt_data,
	input  logic      fdiv_is_sqrt,
	output logic      fpr_gnt_fdiv,
	output logic      fpr_gnt_fadd_fsub,
	output logic      fpr_gnt_fmul,
	output logic      fpr_gnt_itof,
	output logic      fpr_gnt_lw,
	output logic      fpr_gnt_fmov,
	output logic      fpr_gnt_in,
	// operand reads
	input  cdb_t      gpr_arch_read [2],
	input  cdb_t      fpr_arch_read [2],
	input  rob_read_t gpr_rob_read [2],
	input  rob_read_t fpr_rob_read [2],
	output cdb_t      gpr_read [2],
	output cdb_t      fpr_read [2],
	output cdb_t      gpr_cdb,
	output cdb_t      fpr_cdb
);

	gpr_cdb_sched u_gpr_cdb_sched (
		.clk,
		.arst_n,
		.flush,
		.gpr_issue_tag,
		.req_ftoi    (gpr_req_ftoi),
		.req_lw      (gpr_req_lw),
		.req_add_sub (gpr_req_add_sub),
		.req_next    (gpr_req_next),
		.req_mov     (gpr_req_mov),
		.req_in      (gpr_req_in),
		.gnt_ftoi    (gpr_gnt_ftoi),
		.gnt_lw      (gpr_gnt_lw),
		.gnt_add_sub (gpr_gnt_add_sub),
		.gnt_next    (gpr_gnt_next),
		.gnt_mov     (gpr_gnt_mov),
		.gnt_in      (gpr_gnt_in),
		.cdb         (gpr_cdb)
	);

	fpr_cdb_sched u_fpr_cdb_sched (
		.clk,
		.arst_n,
		.flush,
		.fpr_issue_tag,
		.req_fdiv      (fpr_req_fdiv),
		.req_fadd_fsub (fpr_req_fadd_fsub),
		.req_fmul      (fpr_req_fmul),
		.req_itof      (fpr_req_itof),
		.req_lw        (fpr_req_lw),
		.req_fmov      (fpr_req_fmov),
		.req_in        (fpr_req_in),
		.fsqrt_data,
		.fdiv_is_sqrt,
		.gnt_fdiv      (fpr_gnt_fdiv),
		.gnt_fadd_fsub (fpr_gnt_fadd_fsub),
		.gnt_fmul      (fpr_gnt_fmul),
		.gnt_itof      (fpr_gnt_itof),
		.gnt_lw        (fpr_gnt_lw),
		.gnt_fmov      (fpr_gnt_fmov),
		.gnt_in        (fpr_gnt_in),
		.cdb           (fpr_cdb)
	);

	// each read port forwards from its own bus
	operand_bypass u_gpr_bypass (
		.arch_read (gpr_arch_read),
		.rob_read  (gpr_rob_read),
		.cdb       (gpr_cdb),
		.read      (gpr_read)
	);

	operand_bypass u_fpr_bypass (
		.arch_read (fpr_arch_read),
		.rob_read  (fpr_rob_read),
		.cdb       (fpr_cdb),
		.read      (fpr_read)
	);

endmodule

`default_nettype wire

//--- testbench/writeback_bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_bus_checker
	import core_pkg::*;
(
	input logic    clk,
	input logic    arst_n,
	input logic    flush,
	input wb_req_t gpr_req_ftoi,
	input wb_req_t fpr_req_fdiv,
	input wb_req_t gpr_req_in,
	input wb_req_t fpr_req_in,
	input logic    gpr_gnt_ftoi,
	input logic    fpr_gnt_fdiv,
	input cdb_t    gpr_cdb,
	input cdb_t    fpr_cdb
);

	a_always_gnt: assert property (@(posedge clk) disable iff (!arst_n)
		gpr_gnt_ftoi && fpr_gnt_fdiv)
		else $error("ftoi or fdiv grant low");

	// fixed latency, unless a flush comes in between
	a_ftoi_lat: assert property (@(posedge clk) disable iff (!arst_n)
		(gpr_req_ftoi.valid && !flush) ##1 (!flush) [*2] |=>
		(gpr_cdb.valid && gpr_cdb.tag == $past(gpr_req_ftoi.tag, 3)))
		else $error("ftoi result missing on gpr bus");

	a_fdiv_lat: assert property (@(posedge clk) disable iff (!arst_n)
		(fpr_req_fdiv.valid && !flush) ##1 (!flush) [*13] |=>
		(fpr_cdb.valid && fpr_cdb.tag == $past(fpr_req_fdiv.tag, 14)))
		else $error("fdiv result missing on fpr bus");

	a_flush_empty: assert property (@(posedge clk) disable iff (!arst_n)
		flush |=> ((!gpr_cdb.valid || gpr_req_in.valid) && (!fpr_cdb.valid || fpr_req_in.valid)))
		else $error("slot broadcast after flush");

endmodule

`default_nettype wire

//--- testbench/tb_writeback_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_writeback_bus
	import core_pkg::*, cdb_pkg::*;
();

	localparam int PERIOD = 4;

	// gpr unit bits 5 ftoi 4 lw 3 add_sub 2 next 1 mov 0 in
	// fpr unit bits 6 fdiv 5 fadd_fsub 4 fmul 3 itof 2 lw 1 fmov 0 in
	typedef struct packed {
		int gap;
		logic [5:0] greq;
		logic [6:0] freq;
		logic sqrt;
		logic flush;
		logic [5:0] ggnt;
		logic [6:0] fgnt;
	} row_t;

	logic clk;
	logic arst_n;
	logic flush;
	tag_t gpr_issue_tag;
	tag_t fpr_issue_tag;
	wb_req_t g_req [6];
	wb_req_t f_req [7];
	word_t fsqrt_data;
	logic fdiv_is_sqrt;
	logic [5:0] g_gnt;
	logic [6:0] f_gnt;
	cdb_t gpr_arch_read [2];
	cdb_t fpr_arch_read [2];
	rob_read_t gpr_rob_read [2];
	rob_read_t fpr_rob_read [2];
	cdb_t gpr_read [2];
	cdb_t fpr_read [2];
	cdb_t gpr_cdb;
	cdb_t fpr_cdb;

	row_t rows [$];
	cdb_t exp_g [int];
	cdb_t exp_f [int];
	cdb_t bus_g;
	cdb_t bus_f;
	cdb_t rd_g [2];
	cdb_t rd_f [2];
	tag_t g_tag [6];
	tag_t f_tag [7];
	word_t g_dat [6];
	word_t f_dat [7];
	int g_lat [6];
	int f_lat [7];
	int cyc;
	logic [31:0] rng_state = 32'hfffa2008;

	writeback_bus u_writeback_bus (
		.clk, .arst_n, .flush, .gpr_issue_tag, .fpr_issue_tag,
		.gpr_req_ftoi (g_req[5]), .gpr_req_lw (g_req[4]), .gpr_req_add_sub (g_req[3]),
		.gpr_req_next (g_req[2]), .gpr_req_mov (g_req[1]), .gpr_req_in (g_req[0]),
		.gpr_gnt_ftoi (g_gnt[5]), .gpr_gnt_lw (g_gnt[4]), .gpr_gnt_add_sub (g_gnt[3]),
		.gpr_gnt_next (g_gnt[2]), .gpr_gnt_mov (g_gnt[1]), .gpr_gnt_in (g_gnt[0]),
		.fpr_req_fdiv (f_req[6]), .fpr_req_fadd_fsub (f_req[5]), .fpr_req_fmul (f_req[4]),
		.fpr_req_itof (f_req[3]), .fpr_req_lw (f_req[2]), .fpr_req_fmov (f_req[1]),
		.fpr_req_in (f_req[0]), .fsqrt_data, .fdiv_is_sqrt,
		.fpr_gnt_fdiv (f_gnt[6]), .fpr_gnt_fadd_fsub (f_gnt[5]), .fpr_gnt_fmul (f_gnt[4]),
		.fpr_gnt_itof (f_gnt[3]), .fpr_gnt_lw (f_gnt[2]), .fpr_gnt_fmov (f_gnt[1]),
		.fpr_gnt_in (f_gnt[0]),
		.gpr_arch_read, .fpr_arch_read, .gpr_rob_read, .fpr_rob_read,
		.gpr_read, .fpr_read, .gpr_cdb, .fpr_cdb
	);

	bind writeback_bus writeback_bus_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// helpers

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	task automatic fail(input string msg);
		$display("Fail at %0t: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_gnt(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			fail($sformatf("%s grant %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_bus(input cdb_t got, input cdb_t exp, input string what);
		if (got.valid !== exp.valid ||
		    (exp.valid && (got.tag !== exp.tag || got.data !== exp.data))) begin
			fail($sformatf("%s bus %h, expected %h", what, got, exp));
		end
	endtask

	task automatic check_read(input cdb_t got, input cdb_t exp, input string what);
		if (got !== exp) begin
			fail($sformatf("%s read %h, expected %h", what, got, exp));
		end
	endtask

	// architectural first, then the bus, then the rob
	function automatic cdb_t expect_read(cdb_t arch, rob_read_t rob, cdb_t bus);
		cdb_t r;
		logic hit;
		hit = bus.valid && bus.tag == arch.tag;
		r.valid = arch.valid | hit | rob.valid;
		r.tag = arch.tag;
		r.data = arch.valid ? arch.data : (hit ? bus.data : rob.data);
		return r;
	endfunction

	task automatic drive_reads();
		cdb_t a;
		rob_read_t r;
		logic [31:0] x;
		for (int i = 0; i < 2; i++) begin
			x = next_rand();
			a = '{x[0], x[1] ? bus_g.tag : tag_t'(x[7:4]), next_rand()};
			r = '{x[2], next_rand()};
			gpr_arch_read[i] <= a;
			gpr_rob_read[i] <= r;
			rd_g[i] = expect_read(a, r, bus_g);
			a = '{x[8], x[9] ? bus_f.tag : tag_t'(x[15:12]), next_rand()};
			r = '{x[10], next_rand()};
			fpr_arch_read[i] <= a;
			fpr_rob_read[i] <= r;
			rd_f[i] = expect_read(a, r, bus_f);
		end
	endtask

	task automatic add_row(input int gap, input logic [5:0] greq, input logic [6:0] freq,
	                       input logic sqrt, input logic fl,
	                       input logic [5:0] ggnt, input logic [6:0] fgnt);
		rows.push_back(row_t'{gap, greq, freq, sqrt, fl, ggnt, fgnt});
	endtask

	task automatic run_cycle(input row_t r);
		@(posedge clk);
		for (int i = 0; i < 6; i++) begin
			g_req[i] <= '{r.greq[i], g_tag[i], g_dat[i]};
			if (r.greq[i] && r.ggnt[i]) begin
				exp_g[cyc + g_lat[i]] = '{1'b1, g_tag[i], g_dat[i]};
			end
		end
		for (int i = 0; i < 7; i++) begin
			f_req[i] <= '{r.freq[i], f_tag[i], f_dat[i]};
			if (r.freq[i] && r.fgnt[i]) begin
				exp_f[cyc + f_lat[i]] = '{1'b1, f_tag[i],
				                          (i == 6 && r.sqrt) ? fsqrt_data : f_dat[i]};
			end
		end
		fdiv_is_sqrt <= r.sqrt;
		flush <= r.flush;
		// a flush drops everything not yet on the bus
		if (r.flush) begin
			for (int k = cyc + 1; k <= cyc + LAT_FDIV; k++) begin
				if (exp_g.exists(k)) begin
					exp_g.delete(k);
				end
				if (exp_f.exists(k)) begin
					exp_f.delete(k);
				end
			end
		end
		bus_g = exp_g.exists(cyc) ? exp_g[cyc] : '0;
		bus_f = exp_f.exists(cyc) ? exp_f[cyc] : '0;
		drive_reads();
		@(negedge clk);
		for (int i = 0; i < 6; i++) begin
			if (r.greq[i]) begin
				check_gnt(g_gnt[i], r.ggnt[i], $sformatf("gpr unit %0d", i));
			end
		end
		for (int i = 0; i < 7; i++) begin
			if (r.freq[i]) begin
				check_gnt(f_gnt[i], r.fgnt[i], $sformatf("fpr unit %0d", i));
			end
		end
		check_bus(gpr_cdb, bus_g, $sformatf("gpr cycle %0d", cyc));
		check_bus(fpr_cdb, bus_f, $sformatf("fpr cycle %0d", cyc));
		for (int i = 0; i < 2; i++) begin
			check_read(gpr_read[i], rd_g[i], $sformatf("gpr port %0d", i));
			check_read(fpr_read[i], rd_f[i], $sformatf("fpr port %0d", i));
		end
		cyc++;
	endtask

	////////////////////////////////////////////////////////////
	// stimulus

	initial begin
		row_t idle;
		idle = '0;
		arst_n = 1'b0;
		flush = 1'b0;
		fdiv_is_sqrt = 1'b0;
		for (int i = 0; i < 2; i++) begin
			gpr_arch_read[i] = '0;
			fpr_arch_read[i] = '0;
			gpr_rob_read[i] = '0;
			fpr_rob_read[i] = '0;
		end
		for (int i = 0; i < 7; i++) begin
			f_req[i] = '0;
			f_tag[i] = tag_t'(next_rand());
			f_dat[i] = next_rand();
			if (i < 6) begin
				g_req[i] = '0;
				g_tag[i] = tag_t'(next_rand());
				g_dat[i] = next_rand();
			end
		end
		gpr_issue_tag = g_tag[0];
		fpr_issue_tag = f_tag[0];
		fsqrt_data = next_rand();
		g_lat = '{0, 1, 1, 1, 1, LAT_FTOI};
		f_lat = '{0, 1, 1, LAT_ITOF, LAT_FMUL, LAT_FADD, LAT_FDIV};

		// each unit alone
		add_row(2, 6'b100000, 7'b0, 0, 0, 6'b100000, 7'b0);
		for (int i = 4; i >= 0; i--) begin
			add_row(16, 6'(1 << i), 7'b0, 0, 0, 6'(1 << i), 7'b0);
		end
		for (int i = 6; i >= 0; i--) begin
			add_row(16, 6'b0, 7'(1 << i), 0, 0, 6'b0, 7'(1 << i));
		end
		// one-cycle priority then ftoi blocking slot 1 and slot 0
		add_row(16, 6'b011110, 7'b0, 0, 0, 6'b010000, 7'b0);
		add_row(16, 6'b100000, 7'b0, 0, 0, 6'b100000, 7'b0);
		add_row(1, 6'b011110, 7'b0, 0, 0, 6'b000000, 7'b0);
		add_row(0, 6'b000001, 7'b0, 0, 0, 6'b000000, 7'b0);
		// fpr entry slot conflicts and fsqrt select
		add_row(16, 6'b0, 7'b1000000, 1, 0, 6'b0, 7'b1000000);
		add_row(7, 6'b0, 7'b0100000, 0, 0, 6'b0, 7'b0000000);
		add_row(16, 6'b0, 7'b0100000, 0, 0, 6'b0, 7'b0100000);
		add_row(1, 6'b0, 7'b0010000, 0, 0, 6'b0, 7'b0000000);
		add_row(16, 6'b0, 7'b0010000, 0, 0, 6'b0, 7'b0010000);
		add_row(0, 6'b0, 7'b0001000, 0, 0, 6'b0, 7'b0000000);
		add_row(16, 6'b0, 7'b0000110, 0, 0, 6'b0, 7'b0000100);
		// flush just before the ftoi reaches the bus then normal traffic again
		add_row(16, 6'b100000, 7'b1100000, 0, 0, 6'b100000, 7'b1100000);
		add_row(1, 6'b0, 7'b0, 0, 1, 6'b0, 7'b0);
		add_row(3, 6'b010000, 7'b0000100, 0, 0, 6'b010000, 7'b0000100);

		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		cyc = 0;
		foreach (rows[n]) begin
			repeat (rows[n].gap) run_cycle(idle);
			run_cycle(rows[n]);
		end
		repeat (16) run_cycle(idle);
		$display("All tests passed");
		$finish;
	end

	initial begin
		#1;
		#((rows.size() * 20 + 8) * PERIOD);
		$display("timeout: the test did not finish in the expected time");
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- writeback_bus.f
hw/core_pkg.sv
hw/cdb_pkg.sv
hw/gpr_cdb_sched.sv
hw/fpr_cdb_sched.sv
hw/operand_bypass.sv
hw/writeback_bus.sv
testbench/writeback_bus_checker.sv
testbench/tb_writeback_bus.sv

//--- Bender.yml
package:
  name: writeback_bus

sources:
  - hw/core_pkg.sv
  - hw/cdb_pkg.sv
  - hw/gpr_cdb_sched.sv
  - hw/fpr_cdb_sched.sv
  - hw/operand_bypass.sv
  - hw/writeback_bus.sv
  - target: test
    files:
      - testbench/writeback_bus_checker.sv
      - testbench/tb_writeback_bus.sv
